// ==== logic/core_types_pkg.sv ====
////////////////////////////////////////
// Core-wide widths and vector types
// Thread count, thread index and bitmap
// Register file geometry and data words
////////////////////////////////////////

package core_types_pkg;

    // Hardware threads sharing the pipeline
    localparam int NUM_THREADS = 4;
    localparam int NUM_REGISTERS = 16;           // Per thread
    localparam int SCALAR_WIDTH = 32;

    // Thread numbering
    typedef logic [$clog2(NUM_THREADS) - 1:0] thread_idx_t;
    typedef logic [NUM_THREADS - 1:0] thread_bitmap_t;     // One bit per thread

    // Register numbering inside one thread
    typedef logic [$clog2(NUM_REGISTERS) - 1:0] register_idx_t;

    // Data path words
    typedef logic [SCALAR_WIDTH - 1:0] scalar_t;
    typedef logic [SCALAR_WIDTH - 1:0] instruction_t;     // Raw encoded word

endpackage

// ==== logic/isa_pkg.sv ====
////////////////////////////////////////
// Small integer ISA definitions
// Opcode encoding and field positions
// Immediate and shift amount types
////////////////////////////////////////

package isa_pkg;

    // Unlisted encodings execute as op_add
    typedef enum logic [3:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        op_shl  = 4'h5,
        op_shr  = 4'h6,          // Logical shift
        op_movi = 4'h7,          // Zero-extended immediate
        op_addi = 4'h8           // Sign-extended immediate
    } opcode_t;

    typedef logic [15:0] immediate_t;
    typedef logic [4:0] shift_amount_t;          // Low bits of source 2

    // Low bit of each instruction field
    localparam int OPCODE_LSB = 28;
    localparam int DEST_LSB = 24;
    localparam int SRC1_LSB = 20;
    localparam int SRC2_LSB = 16;
    localparam int IMMEDIATE_LSB = 0;

endpackage

// ==== logic/writeback_if.sv ====
////////////////////////////////////////
// Writeback bus from the execute stage
// Modports for driver, register file
// and thread scheduler
////////////////////////////////////////

interface writeback_if;
    import core_types_pkg::*;

    logic          wb_en;            // One cycle per retired instruction
    thread_idx_t   wb_thread_idx;
    register_idx_t wb_reg;           // Destination register
    scalar_t       wb_value;

    // Produced by int_execute_stage
    modport execute(output wb_en, wb_thread_idx, wb_reg, wb_value);

    // Register file write port
    modport regfile(input wb_en, wb_thread_idx, wb_reg, wb_value);

    // Scheduler only needs to know which thread finished
    modport select(input wb_en, wb_thread_idx);

endinterface

// ==== logic/instruction_queue.sv ====
////////////////////////////////////////
// Per-thread instruction FIFOs
// Push and pop strobes, head words
// Empty and full levels per thread
////////////////////////////////////////

module instruction_queue #(
    parameter int QUEUE_DEPTH = 4                          // Power of two
) (
    input                                  clk,
    input                                  reset,
    input                                  push_en,
    input core_types_pkg::thread_idx_t     push_thread_idx,
    input core_types_pkg::instruction_t    push_instruction,
    input                                  pop_en,
    input core_types_pkg::thread_idx_t     pop_thread_idx,
    output core_types_pkg::instruction_t   head_instruction[core_types_pkg::NUM_THREADS],
    output core_types_pkg::thread_bitmap_t queue_empty,
    output core_types_pkg::thread_bitmap_t queue_full
);
    import core_types_pkg::*;

    localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

    typedef logic [PTR_WIDTH - 1:0] queue_ptr_t;
    typedef logic [PTR_WIDTH:0] queue_count_t;             // Holds 0 to QUEUE_DEPTH

    instruction_t fifo_data[NUM_THREADS][QUEUE_DEPTH];     // Payload only
    queue_ptr_t   rd_ptr[NUM_THREADS];
    queue_ptr_t   wr_ptr[NUM_THREADS];
    queue_count_t count[NUM_THREADS];
    thread_bitmap_t push_ok;                               // Accepted pushes
    thread_bitmap_t pop_ok;

    // Status and head words
    always_comb begin
        for (int t = 0; t < NUM_THREADS; t++) begin
            queue_empty[t] = count[t] == '0;
            queue_full[t] = count[t] == queue_count_t'(QUEUE_DEPTH);
            head_instruction[t] = fifo_data[t][rd_ptr[t]];
        end
    end

    // Push to a full queue is dropped
    assign push_ok = push_en ? (thread_bitmap_t'(1'b1) << push_thread_idx) & ~queue_full : '0;
    assign pop_ok = pop_en ? (thread_bitmap_t'(1'b1) << pop_thread_idx) & ~queue_empty : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                rd_ptr[t] <= '0;
                wr_ptr[t] <= '0;
                count[t] <= '0;
            end
        end else begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                if (push_ok[t])
                    wr_ptr[t] <= wr_ptr[t] + 1'b1;         // Wraps at depth

                if (pop_ok[t])
                    rd_ptr[t] <= rd_ptr[t] + 1'b1;

                if (push_ok[t] && !pop_ok[t])
                    count[t] <= count[t] + 1'b1;
                else if (pop_ok[t] && !push_ok[t])
                    count[t] <= count[t] - 1'b1;           // Both at once leaves count
            end
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (push_ok[push_thread_idx])
            fifo_data[push_thread_idx][wr_ptr[push_thread_idx]] <= push_instruction;
    end

endmodule

// ==== logic/thread_select_stage.sv ====
////////////////////////////////////////
// Round-robin thread scheduler
// In-flight tracking per thread
// Issue register and issue event
////////////////////////////////////////

module thread_select_stage (
    input                                  clk,
    input                                  reset,
    input core_types_pkg::thread_bitmap_t  thread_en,
    input core_types_pkg::thread_bitmap_t  queue_empty,
    input core_types_pkg::instruction_t    head_instruction[core_types_pkg::NUM_THREADS],

    // To instruction_queue
    output logic                           pop_en,
    output core_types_pkg::thread_idx_t    pop_thread_idx,

    // To operand_fetch_stage
    output logic                           ts_instruction_valid,
    output core_types_pkg::thread_idx_t    ts_thread_idx,
    output core_types_pkg::instruction_t   ts_instruction,

    writeback_if.select                    wb,
    output logic                           perf_issue
);
    import core_types_pkg::*;

    thread_bitmap_t thread_in_flight;      // Issued, not yet written back
    thread_bitmap_t thread_ready;
    thread_bitmap_t issue_set_mask;
    thread_bitmap_t wb_clear_mask;
    thread_idx_t    rr_ptr;                // First thread to consider
    thread_idx_t    issue_thread_idx;
    logic           issue_found;

    assign thread_ready = thread_en & ~queue_empty & ~thread_in_flight;

    // Walk down from the far end so the closest ready thread wins
    always_comb begin
        issue_found = 1'b0;
        issue_thread_idx = rr_ptr;
        for (int offset = NUM_THREADS - 1; offset >= 0; offset--) begin
            if (thread_ready[thread_idx_t'(rr_ptr + offset)]) begin
                issue_found = 1'b1;
                issue_thread_idx = thread_idx_t'(rr_ptr + offset);   // Modulo thread count
            end
        end
    end

    // Pop in the same cycle the word is registered
    assign pop_en = issue_found;
    assign pop_thread_idx = issue_thread_idx;

    assign issue_set_mask = thread_bitmap_t'(issue_found) << issue_thread_idx;
    assign wb_clear_mask = thread_bitmap_t'(wb.wb_en) << wb.wb_thread_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            thread_in_flight <= '0;
            rr_ptr <= '0;
            ts_instruction_valid <= 1'b0;
        end else begin
            // Bit cleared at the writeback edge, eligible on the next one
            thread_in_flight <= (thread_in_flight & ~wb_clear_mask) | issue_set_mask;
            if (issue_found)
                rr_ptr <= issue_thread_idx + 1'b1;         // Skip past the winner

            ts_instruction_valid <= issue_found;
        end
    end

    // Issue payload
    always_ff @(posedge clk) begin
        ts_thread_idx <= issue_thread_idx;
        ts_instruction <= head_instruction[issue_thread_idx];
    end

    assign perf_issue = ts_instruction_valid;      // One pulse per issue

endmodule

// ==== logic/operand_fetch_stage.sv ====
////////////////////////////////////////
// Per-thread register files
// Source operand read and pipeline reg
////////////////////////////////////////

module operand_fetch_stage (
    input                                  clk,
    input                                  reset,

    // From thread_select_stage
    input                                  ts_instruction_valid,
    input core_types_pkg::thread_idx_t     ts_thread_idx,
    input core_types_pkg::instruction_t    ts_instruction,

    writeback_if.regfile                   wb,

    // To int_execute_stage
    output logic                           of_instruction_valid,
    output core_types_pkg::thread_idx_t    of_thread_idx,
    output core_types_pkg::instruction_t   of_instruction,
    output core_types_pkg::scalar_t        of_operand1,
    output core_types_pkg::scalar_t        of_operand2
);
    import core_types_pkg::*;
    import isa_pkg::*;

    scalar_t       registers[NUM_THREADS][NUM_REGISTERS];
    register_idx_t src1_reg;
    register_idx_t src2_reg;

    // Source fields of the selected word
    assign src1_reg = register_idx_t'(ts_instruction >> SRC1_LSB);
    assign src2_reg = register_idx_t'(ts_instruction >> SRC2_LSB);

    // Register file write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                for (int r = 0; r < NUM_REGISTERS; r++)
                    registers[t][r] <= '0;         // All registers start at zero
            end
        end else if (wb.wb_en) begin
            registers[wb.wb_thread_idx][wb.wb_reg] <= wb.wb_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            of_instruction_valid <= 1'b0;
        else
            of_instruction_valid <= ts_instruction_valid;
    end

    // Operands and instruction carried to execute
    always_ff @(posedge clk) begin
        of_thread_idx <= ts_thread_idx;
        of_instruction <= ts_instruction;
        // In-flight rule keeps this thread's pending write out of the way
        of_operand1 <= registers[ts_thread_idx][src1_reg];
        of_operand2 <= registers[ts_thread_idx][src2_reg];
    end

endmodule

// ==== logic/int_execute_stage.sv ====
////////////////////////////////////////
// Integer ALU
// Writeback register and retire event
////////////////////////////////////////

module int_execute_stage (
    input                                  clk,
    input                                  reset,

    // From operand_fetch_stage
    input                                  of_instruction_valid,
    input core_types_pkg::thread_idx_t     of_thread_idx,
    input core_types_pkg::instruction_t    of_instruction,
    input core_types_pkg::scalar_t         of_operand1,
    input core_types_pkg::scalar_t         of_operand2,

    writeback_if.execute                   wb,
    output logic                           perf_retire
);
    import core_types_pkg::*;
    import isa_pkg::*;

    opcode_t       opcode;
    immediate_t    immediate;
    shift_amount_t shift_amount;
    register_idx_t dest_reg;
    scalar_t       result;

    // Field decode
    assign opcode = opcode_t'(of_instruction[OPCODE_LSB +: $bits(opcode_t)]);
    assign dest_reg = register_idx_t'(of_instruction >> DEST_LSB);
    assign immediate = immediate_t'(of_instruction >> IMMEDIATE_LSB);
    assign shift_amount = shift_amount_t'(of_operand2);    // Low 5 bits only

    always_comb begin
        unique case (opcode)
            op_add:  result = of_operand1 + of_operand2;
            op_sub:  result = of_operand1 - of_operand2;
            op_and:  result = of_operand1 & of_operand2;
            op_or:   result = of_operand1 | of_operand2;
            op_xor:  result = of_operand1 ^ of_operand2;
            op_shl:  result = of_operand1 << shift_amount;
            op_shr:  result = of_operand1 >> shift_amount;         // Zero fill
            op_movi: result = scalar_t'(immediate);                // Zero extend
            op_addi: result = of_operand1 + scalar_t'(signed'(immediate));  // Sign extend
            default: result = of_operand1 + of_operand2;           // Unknown acts as add
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            wb.wb_en <= 1'b0;
        else
            wb.wb_en <= of_instruction_valid;
    end

    // Writeback payload
    always_ff @(posedge clk) begin
        wb.wb_thread_idx <= of_thread_idx;
        wb.wb_reg <= dest_reg;
        wb.wb_value <= result;
    end

    assign perf_retire = wb.wb_en;         // Every writeback retires one

endmodule

// ==== logic/core.sv ====
////////////////////////////////////////
// Barrel-threaded integer core
// Queue, select, fetch, execute stages
// Writeback and events as plain ports
////////////////////////////////////////

module core #(
    parameter int QUEUE_DEPTH = 4
) (
    input                                  clk,
    input                                  reset,
    input core_types_pkg::thread_bitmap_t  thread_en,

    // Instruction loading by the external agent
    input                                  instr_push_en,
    input core_types_pkg::thread_idx_t     instr_push_thread_idx,
    input core_types_pkg::instruction_t    instr_push_word,
    output core_types_pkg::thread_bitmap_t instr_queue_full,

    // Writeback observation
    output logic                           wb_en,
    output core_types_pkg::thread_idx_t    wb_thread_idx,
    output core_types_pkg::register_idx_t  wb_reg,
    output core_types_pkg::scalar_t        wb_value,

    // Performance events
    output logic                           perf_issue,
    output logic                           perf_retire
);
    import core_types_pkg::*;

    logic           pop_en;
    thread_idx_t    pop_thread_idx;
    instruction_t   head_instruction[NUM_THREADS];
    thread_bitmap_t queue_empty;
    logic           ts_instruction_valid;
    thread_idx_t    ts_thread_idx;
    instruction_t   ts_instruction;
    logic           of_instruction_valid;
    thread_idx_t    of_thread_idx;
    instruction_t   of_instruction;
    scalar_t        of_operand1;
    scalar_t        of_operand2;

    writeback_if wb();                     // Shared by execute, fetch and select

    instruction_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) instruction_queue(
        .push_en(instr_push_en),
        .push_thread_idx(instr_push_thread_idx),
        .push_instruction(instr_push_word),
        .queue_full(instr_queue_full),
        .*);
    thread_select_stage thread_select_stage(.wb(wb), .*);
    operand_fetch_stage operand_fetch_stage(.wb(wb), .*);
    int_execute_stage int_execute_stage(.wb(wb), .*);

    // Writeback bus out to pins
    assign wb_en = wb.wb_en;
    assign wb_thread_idx = wb.wb_thread_idx;
    assign wb_reg = wb.wb_reg;
    assign wb_value = wb.wb_value;

endmodule

// ==== test/clock_gen.sv ====
////////////////////////////////////////
// Testbench clock and reset source
////////////////////////////////////////

module clock_gen #(
    parameter int PERIOD_NS = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;                         // Released just after the last reset edge
    end

endmodule

// ==== test/core_tb.sv ====
////////////////////////////////////////
// Testbench for the threaded core
// Stimulus player from a data file
// Writeback monitor and event counters
// Watchdog and closing summary
////////////////////////////////////////

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_types_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_RECORDS = 128;
    localparam int CYCLES_PER_RECORD = 200;        // Watchdog budget
    localparam int DRAIN_CYCLES = 100;
    localparam logic [3:0] CMD_PUSH = 4'h1;
    localparam logic [3:0] CMD_ENABLE = 4'h2;
    localparam logic [3:0] CMD_IDLE = 4'h3;
    localparam logic [3:0] CMD_EXPECT = 4'h4;
    localparam logic [3:0] CMD_FULL = 4'h5;

    logic           clk;
    logic           reset;
    thread_bitmap_t thread_en;
    logic           instr_push_en;
    thread_idx_t    instr_push_thread_idx;
    instruction_t   instr_push_word;
    thread_bitmap_t instr_queue_full;
    logic           wb_en;
    thread_idx_t    wb_thread_idx;
    register_idx_t  wb_reg;
    scalar_t        wb_value;
    logic           perf_issue;
    logic           perf_retire;

    logic [43:0]    records[MAX_RECORDS];          // {cmd, thread, reg, word}
    logic [35:0]    expected_wb[NUM_THREADS][$];   // {reg, value} in program order
    int             num_records;
    int             push_count, issue_count, retire_count;
    int             value_errors, other_errors;
    thread_bitmap_t ever_enabled = '0;             // Threads seen enabled so far
    logic [31:0]    rand_state = 32'h7e1;
    bit             records_loaded = 1'b0;

    clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) clock_gen_i(.clk(clk), .reset(reset));

    core #(.QUEUE_DEPTH(4)) dut_i(.*);

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state ^ (state << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int pending_writebacks();
        int total;
        total = 0;
        for (int t = 0; t < NUM_THREADS; t++)
            total += expected_wb[t].size();
        return total;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] observed);
        value_errors++;
        $display("ERR t=%0t %s expected %h observed %h", $time, name, expected, observed);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Problem at %0t ns: %s", $time, what);
    endtask

    // Expected writebacks sorted into per-thread queues at load time
    task automatic load_stimulus();
        foreach (records[i])
            records[i] = '0;                       // Command 0 ends the list
        $readmemh("test/core_stimulus.mem", records);
        num_records = 0;
        while (num_records < MAX_RECORDS && records[num_records][43:40] != 4'h0) begin
            if (records[num_records][43:40] == CMD_EXPECT)
                expected_wb[records[num_records][37:36]].push_back(records[num_records][35:0]);
            num_records++;
        end
        records_loaded = 1'b1;
    endtask

    task automatic push_instruction(input thread_idx_t thread, input instruction_t word);
        while (instr_queue_full[thread])
            @(negedge clk);                        // Hold off on a full queue
        instr_push_en = 1'b1;
        instr_push_thread_idx = thread;
        instr_push_word = word;
        @(negedge clk);
        instr_push_en = 1'b0;
        push_count++;
        rand_state = next_random(rand_state);
        repeat (rand_state[1:0]) @(negedge clk);   // 0 to 3 idle cycles
    endtask

    task automatic play_record(input logic [43:0] rec);
        case (rec[43:40])
            CMD_PUSH:   push_instruction(rec[37:36], rec[31:0]);
            CMD_ENABLE: thread_en = rec[3:0];
            CMD_IDLE:   repeat (rec[31:0]) @(negedge clk);
            CMD_EXPECT: begin
            end                                    // Queued at load time
            CMD_FULL:   assert (instr_queue_full == rec[3:0])
                else report_mismatch("instr_queue_full", 32'(rec[3:0]), 32'(instr_queue_full));
            default:    report_failure($sformatf("unknown stimulus command %h", rec[43:40]));
        endcase
    endtask

    task automatic check_writeback();
        logic [35:0] expected;
        assert (ever_enabled[wb_thread_idx])
            else report_failure($sformatf("thread %0d wrote back before it was enabled",
                                          wb_thread_idx));
        assert (expected_wb[wb_thread_idx].size() != 0)
            else report_failure($sformatf("unexpected writeback from thread %0d, r%0d = %h",
                                          wb_thread_idx, wb_reg, wb_value));
        if (expected_wb[wb_thread_idx].size() != 0) begin
            expected = expected_wb[wb_thread_idx].pop_front();
            assert (wb_reg == expected[35:32])
                else report_mismatch($sformatf("wb_reg thread %0d", wb_thread_idx),
                                     32'(expected[35:32]), 32'(wb_reg));
            assert (wb_value == expected[31:0])
                else report_mismatch($sformatf("wb_value thread %0d", wb_thread_idx),
                                     expected[31:0], wb_value);
        end
    endtask

    // Monitor samples on the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            ever_enabled = ever_enabled | thread_en;
            if (perf_issue)
                issue_count++;
            if (perf_retire)
                retire_count++;
            if (wb_en)
                check_writeback();
        end
    end

    // Player drives on the falling edge
    initial begin
        thread_en = '0;
        instr_push_en = 1'b0;
        instr_push_thread_idx = '0;
        instr_push_word = '0;
        load_stimulus();
        @(negedge clk);
        while (reset)
            @(negedge clk);
        for (int i = 0; i < num_records; i++)
            play_record(records[i]);
        for (int c = 0; c < DRAIN_CYCLES && pending_writebacks() != 0; c++)
            @(negedge clk);
        repeat (8) @(negedge clk);                 // Room for stray writebacks
        assert (pending_writebacks() == 0)
            else report_failure($sformatf("%0d expected writebacks never arrived",
                                          pending_writebacks()));
        assert (issue_count == push_count)
            else report_mismatch("perf_issue count", push_count, issue_count);
        assert (retire_count == push_count)
            else report_mismatch("perf_retire count", push_count, retire_count);
        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        wait (records_loaded);
        #(num_records * CYCLES_PER_RECORD * CLK_PERIOD);
        report_failure("watchdog expired before the run finished");
        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== core.f ====
logic/core_types_pkg.sv
logic/isa_pkg.sv
logic/writeback_if.sv
logic/instruction_queue.sv
logic/thread_select_stage.sv
logic/operand_fetch_stage.sv
logic/int_execute_stage.sv
logic/core.sv
test/clock_gen.sv
test/core_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the threaded core

VERILATOR  ?= verilator
TOP        ?= core_tb
RTL_TOP    ?= core
FILELIST   ?= core.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/core_stimulus.mem ====
// Columns: cmd_thread_reg_word. cmd 1 push word, 2 thread_en = word, 3 idle word cycles,
// 4 expect writeback of reg = word, 5 check instr_queue_full = word
2_0_0_0000000B // Threads 0, 1, 3 enabled
1_2_0_71000010 // T2 movi r1, 0x10
4_2_1_00000010
1_2_0_81100001 // T2 addi r1, r1, 1
4_2_1_00000011
1_2_0_81100001
4_2_1_00000012
1_2_0_81100001
4_2_1_00000013
5_0_0_00000004 // Only thread 2 full
1_0_0_71001234 // T0 movi r1, 0x1234
4_0_1_00001234
1_1_0_71000005 // T1 movi r1, 5
4_1_1_00000005
1_3_0_71000007 // T3 movi r1, 7
4_3_1_00000007
1_0_0_720000FF // T0 movi r2, 0xff
4_0_2_000000FF
1_1_0_01110000 // T1 add r1, r1, r1
4_1_1_0000000A
1_3_0_51110000 // T3 shl r1, r1, r1
4_3_1_00000380
1_0_0_03120000 // T0 add r3, r1, r2
4_0_3_00001333
1_0_0_14210000 // T0 sub r4, r2, r1
4_0_4_FFFFEECB
1_0_0_25410000 // T0 and r5, r4, r1
4_0_5_00000200
1_0_0_36520000 // T0 or r6, r5, r2
4_0_6_000002FF
1_0_0_47410000 // T0 xor r7, r4, r1
4_0_7_FFFFFCFF
1_0_0_58220000 // T0 shl r8, r2, r2 by 31
4_0_8_80000000
1_0_0_69420000 // T0 shr r9, r4, r2 by 31
4_0_9_00000001
1_0_0_8A10FFF0 // T0 addi r10, r1, -16
4_0_A_00001224
3_0_0_00000014 // Thread 2 must stay silent
2_0_0_0000000F
1_2_0_81100001 // Waits on the full queue
4_2_1_00000014
